// File: Makefile
# Verilator flow for the MIPS fetch subsystem

VERILATOR ?= verilator
TOP       ?= tb_mips_fetch
FLIST     ?= mips_fetch.f
TIMEOUT   ?= 4000
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

# Pass only when the run prints the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -GTIMEOUT_CYCLES=$(TIMEOUT) \
		-Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: mips_fetch.f
src/fetch_pkg.sv
src/prog_mem.sv
src/pc_unit.sv
src/instr_decoder.sv
src/fetch_ctrl.sv
src/mips_fetch_top.sv
tests/mips_fetch_properties.sv
tests/tb_mips_fetch.sv

// File: src/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl #(
  parameter int RAM_DEPTH = 256
) (
  input  logic                i_clk,
  input  logic                i_rsta,
  input  logic                i_soft_reset,   // Erase request, any state
  input  logic                i_load_strobe,  // One word to store
  input  logic                i_run,          // Fetch enable level
  input  logic                i_erase_done,
  input  logic                i_is_jump,      // Decoded from memory output
  input  logic                i_is_halt,
  output logic                o_mem_ena,
  output logic                o_mem_wea,
  output logic                o_start_erase,
  output fetch_pkg::pc_mode_e o_pc_mode,
  output logic                o_busy,
  output logic                o_instr_valid,
  output logic                o_halted
);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_ERASE = 2'd1;
  localparam logic [1:0] ST_RUN   = 2'd2;
  localparam logic [1:0] ST_HALT  = 2'd3;

  // Erase guard, far beyond the longest legal erase
  localparam int WD_W = $clog2(RAM_DEPTH) + 2;

  logic [1:0]      state;
  logic [1:0]      state_nxt;
  logic            rd_pend;                         // Memory output holds a fresh read
  logic            rd_pend_nxt;
  logic            discard;                         // Word behind a jump, drop it
  logic            discard_nxt;
  logic [WD_W-1:0] erase_wd;
  logic            erase_stuck;
  logic            word_live;

  assign word_live   = rd_pend && !discard;
  assign erase_stuck = (erase_wd == '1);

  assign o_start_erase = i_soft_reset;              // Memory restarts on the same edge
  assign o_busy        = (state == ST_ERASE);
  assign o_halted      = (state == ST_HALT);
  assign o_instr_valid = (state == ST_RUN) && i_run && word_live && !i_is_halt;

  ////////////////////
  // Next state and port control

  always_comb begin
    state_nxt   = state;
    rd_pend_nxt = rd_pend;
    discard_nxt = discard;
    o_mem_ena   = 1'b0;
    o_mem_wea   = 1'b0;
    o_pc_mode   = fetch_pkg::PC_HOLD;               // i_run low lands here too
    if (i_soft_reset) begin
      state_nxt   = ST_ERASE;
      rd_pend_nxt = 1'b0;
      discard_nxt = 1'b0;
      o_pc_mode   = fetch_pkg::PC_CLEAR;
    end else begin
      case (state)
        ST_IDLE, ST_HALT: begin
          if (i_load_strobe) begin
            o_mem_ena = 1'b1;                       // Store at PC, then step
            o_mem_wea = 1'b1;
            o_pc_mode = fetch_pkg::PC_INC;
            state_nxt = ST_IDLE;                    // Loading also leaves halt
          end else if (state == ST_IDLE && i_run) begin
            state_nxt = ST_RUN;
          end
        end
        ST_ERASE: begin
          if (i_erase_done || erase_stuck) begin
            state_nxt = ST_IDLE;
          end
        end
        ST_RUN: begin
          if (i_run) begin
            rd_pend_nxt = 1'b1;
            discard_nxt = 1'b0;
            if (word_live && i_is_halt) begin
              state_nxt   = ST_HALT;                // No read, PC stays put
              rd_pend_nxt = 1'b0;
            end else if (word_live && i_is_jump) begin
              o_mem_ena   = 1'b1;                   // This read is thrown away
              o_pc_mode   = fetch_pkg::PC_JUMP;
              discard_nxt = 1'b1;
            end else begin
              o_mem_ena = 1'b1;
              o_pc_mode = fetch_pkg::PC_INC;
            end
          end
        end
      endcase
    end
  end

  ////////////////////
  // State registers

  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      state    <= ST_IDLE;
      rd_pend  <= 1'b0;
      discard  <= 1'b0;
      erase_wd <= '0;
    end else begin
      state   <= state_nxt;
      rd_pend <= rd_pend_nxt;
      discard <= discard_nxt;
      if (state == ST_ERASE && !i_soft_reset) begin
        erase_wd <= erase_wd + 1'b1;                // Counts erase cycles
      end else begin
        erase_wd <= '0;
      end
    end
  end

endmodule

// File: src/fetch_pkg.sv
package fetch_pkg;

  ////////////////////
  // Word constants

  localparam int INSTR_W = 32;                      // Instruction and memory word width

  localparam logic [5:0] OP_J   = 6'd2;             // Absolute jump
  localparam logic [5:0] OP_JAL = 6'd3;             // Jump and link, same redirect here

  // Erased memory reads as all ones, and fetch stops on it
  localparam logic [INSTR_W-1:0] HALT_WORD = '1;

  ////////////////////
  // Instruction views

  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;                            // ALU function select
    } r_fmt;
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;                             // Signed immediate
    } i_fmt;
    struct packed {
      logic [5:0]  opcode;
      logic [25:0] target;                          // Word index of the jump destination
    } j_fmt;
  } instr_u;

  // PC update selected by the controller each cycle
  typedef enum logic [1:0] {
    PC_CLEAR,
    PC_HOLD,
    PC_INC,
    PC_JUMP
  } pc_mode_e;

endpackage

// File: src/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
  input  logic [fetch_pkg::INSTR_W-1:0] i_word,
  output logic [5:0]                    o_opcode,
  output logic [4:0]                    o_rs,
  output logic [4:0]                    o_rt,
  output logic [4:0]                    o_rd,
  output logic [fetch_pkg::INSTR_W-1:0] o_imm,      // Sign extended
  output logic [25:0]                   o_target,
  output logic                          o_is_jump,
  output logic                          o_is_halt
);

  fetch_pkg::instr_u word_u;

  assign word_u = i_word;

  ////////////////////
  // Field split

  // Register fields come from the R view
  assign o_opcode = word_u.r_fmt.opcode;
  assign o_rs     = word_u.r_fmt.rs;
  assign o_rt     = word_u.r_fmt.rt;
  assign o_rd     = word_u.r_fmt.rd;

  assign o_imm = {{(fetch_pkg::INSTR_W - 16){word_u.i_fmt.imm[15]}},
                  word_u.i_fmt.imm};                // I view, upper half copies the sign

  assign o_target = word_u.j_fmt.target;            // J view

  ////////////////////
  // Classification

  assign o_is_jump = (word_u.j_fmt.opcode == fetch_pkg::OP_J) ||
                     (word_u.j_fmt.opcode == fetch_pkg::OP_JAL);

  // Whole-word compare, an opcode of all ones alone is not enough
  assign o_is_halt = (i_word == fetch_pkg::HALT_WORD);

endmodule

// File: src/mips_fetch_top.sv
`timescale 1ns/1ps

module mips_fetch_top #(
  parameter  int RAM_DEPTH = 256,
  localparam int AW        = $clog2(RAM_DEPTH)
) (
  input  logic                          i_clk,
  input  logic                          i_rsta,
  input  logic                          i_soft_reset,
  input  logic                          i_load_strobe,
  input  logic [fetch_pkg::INSTR_W-1:0] i_load_word,
  input  logic                          i_run,
  output logic                          o_busy,
  output logic                          o_overwrite,
  output logic                          o_instr_valid,
  output logic [AW-1:0]                 o_pc,
  output logic [5:0]                    o_opcode,
  output logic [4:0]                    o_rs,
  output logic [4:0]                    o_rt,
  output logic [4:0]                    o_rd,
  output logic [fetch_pkg::INSTR_W-1:0] o_imm,
  output logic [25:0]                   o_target,
  output logic                          o_is_jump,
  output logic                          o_halted
);

  logic                          mem_ena;
  logic                          mem_wea;
  logic                          start_erase;
  logic                          erase_done;
  logic                          is_halt;
  logic [AW-1:0]                 pc;
  logic [fetch_pkg::INSTR_W-1:0] mem_data;
  fetch_pkg::pc_mode_e           pc_mode;

  ////////////////////
  // Control

  fetch_ctrl #(
    .RAM_DEPTH (RAM_DEPTH)
  ) fetch_ctrl_inst (
    .i_clk         (i_clk),
    .i_rsta        (i_rsta),
    .i_soft_reset  (i_soft_reset),
    .i_load_strobe (i_load_strobe),
    .i_run         (i_run),
    .i_erase_done  (erase_done),
    .i_is_jump     (o_is_jump),                     // Also an output of the top
    .i_is_halt     (is_halt),
    .o_mem_ena     (mem_ena),
    .o_mem_wea     (mem_wea),
    .o_start_erase (start_erase),
    .o_pc_mode     (pc_mode),
    .o_busy        (o_busy),
    .o_instr_valid (o_instr_valid),
    .o_halted      (o_halted)
  );

  ////////////////////
  // Datapath

  pc_unit #(
    .RAM_DEPTH (RAM_DEPTH)
  ) pc_unit_inst (
    .i_clk     (i_clk),
    .i_rsta    (i_rsta),
    .i_mode    (pc_mode),
    .i_target  (o_target),
    .o_pc      (pc),
    .o_pc_prev (o_pc)                               // Read address of the word on output
  );

  prog_mem #(
    .RAM_DEPTH (RAM_DEPTH)
  ) prog_mem_inst (
    .i_clk         (i_clk),
    .i_rsta        (i_rsta),
    .i_ena         (mem_ena),
    .i_wea         (mem_wea),
    .i_start_erase (start_erase),
    .i_addr        (pc),
    .i_data        (i_load_word),
    .o_data        (mem_data),
    .o_erase_done  (erase_done),
    .o_overwrite   (o_overwrite)
  );

  instr_decoder instr_decoder_inst (
    .i_word    (mem_data),
    .o_opcode  (o_opcode),
    .o_rs      (o_rs),
    .o_rt      (o_rt),
    .o_rd      (o_rd),
    .o_imm     (o_imm),
    .o_target  (o_target),
    .o_is_jump (o_is_jump),
    .o_is_halt (is_halt)
  );

endmodule

// File: src/pc_unit.sv
`timescale 1ns/1ps

module pc_unit #(
  parameter  int RAM_DEPTH = 256,
  localparam int AW        = $clog2(RAM_DEPTH)
) (
  input  logic                i_clk,
  input  logic                i_rsta,
  input  fetch_pkg::pc_mode_e i_mode,
  input  logic [25:0]         i_target,   // Jump field, word index
  output logic [AW-1:0]       o_pc,       // Memory address, load and fetch alike
  output logic [AW-1:0]       o_pc_prev   // Address of the word leaving memory
);

  ////////////////////
  // Address register

  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      o_pc      <= '0;
      o_pc_prev <= '0;
    end else begin
      case (i_mode)
        fetch_pkg::PC_CLEAR: begin
          o_pc <= '0;
        end
        fetch_pkg::PC_INC: begin
          o_pc      <= o_pc + 1'b1;                 // Wraps at RAM_DEPTH
          o_pc_prev <= o_pc;
        end
        fetch_pkg::PC_JUMP: begin
          o_pc <= i_target[AW-1:0];                 // Upper target bits fall outside memory
        end
        default: begin
          o_pc <= o_pc;                             // Hold
        end
      endcase
    end
  end

endmodule

// File: src/prog_mem.sv
`timescale 1ns/1ps

module prog_mem #(
  parameter  int RAM_DEPTH = 256,
  localparam int AW        = $clog2(RAM_DEPTH)
) (
  input  logic                          i_clk,
  input  logic                          i_rsta,
  input  logic                          i_ena,          // Port enable, low keeps o_data
  input  logic                          i_wea,          // Write when enabled
  input  logic                          i_start_erase,  // Restart erase at address 0
  input  logic [AW-1:0]                 i_addr,
  input  logic [fetch_pkg::INSTR_W-1:0] i_data,
  output logic [fetch_pkg::INSTR_W-1:0] o_data,
  output logic                          o_erase_done,   // One cycle after last erase write
  output logic                          o_overwrite     // Sticky, load hit a live word
);

  logic [fetch_pkg::INSTR_W-1:0] mem [RAM_DEPTH];
  logic [fetch_pkg::INSTR_W-1:0] data_q;            // No-change read register
  logic [AW-1:0]                 erase_cnt;
  logic                          erasing;
  logic                          erase_step;        // Erase write this cycle
  logic                          erase_last;
  logic                          load_wr;

  assign erase_step = erasing && !i_start_erase;
  assign load_wr    = i_ena && i_wea && !erasing && !i_start_erase;

  // Stop at the top, or early once an already erased word is reached
  assign erase_last = (erase_cnt == AW'(RAM_DEPTH - 1)) ||
                      (mem[erase_cnt] == fetch_pkg::HALT_WORD);

  ////////////////////
  // Erase sequencer and overwrite flag

  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      erasing      <= 1'b0;
      erase_cnt    <= '0;
      o_erase_done <= 1'b0;
      o_overwrite  <= 1'b0;
    end else if (i_start_erase) begin
      erasing      <= 1'b1;                         // A new erase also clears the flag
      erase_cnt    <= '0;
      o_erase_done <= 1'b0;
      o_overwrite  <= 1'b0;
    end else begin
      o_erase_done <= 1'b0;
      if (erasing) begin
        if (erase_last) begin
          erasing      <= 1'b0;
          o_erase_done <= 1'b1;
        end else begin
          erase_cnt <= erase_cnt + 1'b1;            // One address per cycle
        end
      end else if (load_wr) begin
        if (mem[i_addr] != fetch_pkg::HALT_WORD) begin
          o_overwrite <= 1'b1;                      // Old word was still a program word
        end
      end
    end
  end

  ////////////////////
  // Storage and read port

  always_ff @(posedge i_clk) begin
    if (erase_step) begin
      mem[erase_cnt] <= fetch_pkg::HALT_WORD;
    end else if (load_wr) begin
      mem[i_addr] <= i_data;
    end
    // Writes leave the output alone
    if (i_ena && !i_wea && !erasing) begin
      data_q <= mem[i_addr];
    end
  end

  assign o_data = data_q;

endmodule

// File: tests/mips_fetch_properties.sv
`timescale 1ns/1ps

module mips_fetch_properties (
  input logic i_clk,
  input logic i_rsta,
  input logic i_soft_reset,   // Erase request
  input logic i_load_strobe,
  input logic i_is_jump,      // Decoded from memory output
  input logic i_valid,        // Controller o_instr_valid
  input logic i_busy,         // Erase in progress
  input logic i_halted
);

  int fail_count = 0;         // Failed assertions so far

  ////////////////////
  // Controller rules

  // An erase request turns into busy on the next cycle and ends fetch and halt
  erase_starts: assert property (@(posedge i_clk) disable iff (i_rsta)
    i_soft_reset |=> i_busy && !i_valid && !i_halted)
    else begin
      $error("soft reset not followed by an erase");
      fail_count++;
    end

  // The word read behind a jump never shows as valid
  jump_bubble: assert property (@(posedge i_clk) disable iff (i_rsta)
    i_valid && i_is_jump && !i_soft_reset |=> !i_valid)
    else begin
      $error("instruction valid right after a jump");
      fail_count++;
    end

  // Only a load or a soft reset leaves halt
  halt_held: assert property (@(posedge i_clk) disable iff (i_rsta)
    i_halted && !i_soft_reset && !i_load_strobe |=> i_halted)
    else begin
      $error("halt left without load or soft reset");
      fail_count++;
    end

endmodule

bind fetch_ctrl mips_fetch_properties fetch_ctrl_props (
  .i_clk         (i_clk),
  .i_rsta        (i_rsta),
  .i_soft_reset  (i_soft_reset),
  .i_load_strobe (i_load_strobe),
  .i_is_jump     (i_is_jump),
  .i_valid       (o_instr_valid),
  .i_busy        (o_busy),
  .i_halted      (o_halted)
);

// File: tests/tb_mips_fetch.sv
`timescale 1ns/1ps

module tb_mips_fetch #(
  parameter int TIMEOUT_CYCLES = 4000   // Tests need about 600 cycles with one full erase
);

  localparam int          RAM_DEPTH = 256;
  localparam int          AW        = $clog2(RAM_DEPTH);
  localparam logic [31:0] HALT      = fetch_pkg::HALT_WORD;

  logic              i_clk = 1'b0;
  logic              i_rsta;
  logic              i_soft_reset;
  logic              i_load_strobe;
  logic [31:0]       i_load_word;
  logic              i_run;
  logic              o_busy;
  logic              o_overwrite;
  logic              o_instr_valid;
  logic [AW-1:0]     o_pc;
  logic [5:0]        o_opcode;
  logic [4:0]        o_rs;
  logic [4:0]        o_rt;
  logic [4:0]        o_rd;
  logic [31:0]       o_imm;
  logic [25:0]       o_target;
  logic              o_is_jump;
  logic              o_halted;

  logic [31:0] model_mem [RAM_DEPTH];               // Reference copy of program memory
  int          model_pc;
  logic        model_ovw;                           // Expected overwrite flag
  int          exp_addr[$];                         // Expected fetch stream
  logic [31:0] exp_word[$];
  logic [31:0] prog_q[$];                           // Words for the next load
  int          seed = 18;
  int          cycles = 0;

  mips_fetch_top #(
    .RAM_DEPTH (RAM_DEPTH)
  ) mips_fetch_top_inst (
    .i_clk (i_clk), .i_rsta (i_rsta), .i_soft_reset (i_soft_reset),
    .i_load_strobe (i_load_strobe), .i_load_word (i_load_word), .i_run (i_run),
    .o_busy (o_busy), .o_overwrite (o_overwrite), .o_instr_valid (o_instr_valid),
    .o_pc (o_pc), .o_opcode (o_opcode), .o_rs (o_rs), .o_rt (o_rt), .o_rd (o_rd),
    .o_imm (o_imm), .o_target (o_target), .o_is_jump (o_is_jump), .o_halted (o_halted)
  );

  always #10 i_clk = ~i_clk;                        // 20 ns period

  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $fatal(1, "Stopped by the cycle limit");
    end
  end

  ////////////////////
  // Helpers

  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("TEST FAIL");
      $fatal(1, "Check failed");
    end
  endtask

  task automatic next_cycle;                        // Drive point 1 ns after the edge
    @(posedge i_clk);
    #1;
  endtask

  function automatic logic [31:0] alu_word(input int n);
    return {6'h00, 5'(n), 5'(n + 1), 5'(n + 2), 5'd0, 6'h20};       // add rd, rs, rt
  endfunction

  function automatic logic [31:0] addi_word(input int n);
    return {6'h08, 5'(n), 5'(n + 7), 16'(100 - n * 40)};            // Mixed sign immediates
  endfunction

  function automatic logic [31:0] jump_word(input int target);
    return {fetch_pkg::OP_J, 26'(target)};
  endfunction

  task automatic apply_reset;
    int k;
    i_rsta = 1'b1;
    for (k = 0; k < 5; k++) begin
      next_cycle();
    end
    i_rsta    = 1'b0;
    model_pc  = 0;                                  // PC and flag clear but memory is kept
    model_ovw = 1'b0;
  endtask

  // Erase rule writes halt words upward and stops at the top or after an already erased word
  task automatic model_erase(output int count);
    logic [31:0] old;
    int          k;
    count = 0;
    for (k = 0; k < RAM_DEPTH; k++) begin
      old          = model_mem[k];
      model_mem[k] = HALT;
      count++;
      if (old == HALT) break;
    end
    model_pc  = 0;
    model_ovw = 1'b0;
  endtask

  task automatic erase_mem(output int busy_cycles);
    int count;
    model_erase(count);
    i_soft_reset = 1'b1;
    next_cycle();
    i_soft_reset = 1'b0;
    busy_cycles  = 0;
    @(negedge i_clk);
    check(64'(o_busy), 64'd1, "o_busy did not rise after soft reset");
    while (o_busy) begin
      busy_cycles++;
      @(negedge i_clk);
    end
    check(64'(busy_cycles <= count + 2), 64'd1, "erase longer than the erase rule allows");
    check(64'(o_overwrite), 64'd0, "o_overwrite after erase");
    check(64'(o_halted), 64'd0, "o_halted after erase");
    next_cycle();
  endtask

  task automatic load_prog;                         // Back to back strobes
    int k;
    for (k = 0; k < prog_q.size(); k++) begin
      i_load_strobe = 1'b1;
      i_load_word   = prog_q[k];
      if (model_mem[model_pc] != HALT) model_ovw = 1'b1;
      model_mem[model_pc] = prog_q[k];
      model_pc = (model_pc + 1) % RAM_DEPTH;
      next_cycle();
    end
    i_load_strobe = 1'b0;
    check(64'(o_overwrite), 64'(model_ovw), "o_overwrite after loading");
    prog_q.delete();
  endtask

  // Walk the model from address 0 and follow jumps up to the halt word
  task automatic build_expected;
    int          addr;
    int          step;
    logic [31:0] w;
    exp_addr.delete();
    exp_word.delete();
    addr = 0;
    for (step = 0; step < 2 * RAM_DEPTH; step++) begin
      w = model_mem[addr];
      if (w == HALT) break;
      exp_addr.push_back(addr);
      exp_word.push_back(w);
      if (w[31:26] == fetch_pkg::OP_J || w[31:26] == fetch_pkg::OP_JAL) begin
        addr = 32'(w[AW-1:0]);                      // Target truncated to memory size
      end else begin
        addr = (addr + 1) % RAM_DEPTH;
      end
    end
  endtask

  task automatic check_fetch;
    int          a;
    logic [31:0] w;
    logic        jmp;
    check(64'(exp_addr.size() > 0), 64'd1, "valid strobe beyond the expected stream");
    a   = exp_addr.pop_front();
    w   = exp_word.pop_front();
    jmp = (w[31:26] == fetch_pkg::OP_J) || (w[31:26] == fetch_pkg::OP_JAL);
    check(64'(o_pc), 64'(a), "o_pc");
    check(64'(o_opcode), 64'(w[31:26]), "o_opcode");
    check(64'(o_rs), 64'(w[25:21]), "o_rs");
    check(64'(o_rt), 64'(w[20:16]), "o_rt");
    check(64'(o_rd), 64'(w[15:11]), "o_rd");
    check(64'(o_imm), 64'({{16{w[15]}}, w[15:0]}), "o_imm");
    check(64'(o_target), 64'(w[25:0]), "o_target");
    check(64'(o_is_jump), 64'(jmp), "o_is_jump");
  endtask

  // Run from PC 0 until halt with an optional pause after a given number of strobes
  task automatic run_program(input int pause_at, input int pause_len);
    int seen;
    int k;
    build_expected();
    seen  = 0;
    i_run = 1'b1;
    @(negedge i_clk);
    while (!o_halted) begin
      if (o_instr_valid) begin
        check_fetch();
        seen++;
        if (seen == pause_at) begin
          next_cycle();
          i_run = 1'b0;
          for (k = 0; k < pause_len; k++) begin
            @(negedge i_clk);
            check(64'(o_instr_valid), 64'd0, "valid strobe while i_run low");
            next_cycle();
          end
          i_run = 1'b1;
        end
      end
      @(negedge i_clk);
    end
    check(64'(exp_addr.size()), 64'd0, "halted before the end of the stream");
    next_cycle();
    i_run = 1'b0;
  endtask

  ////////////////////
  // Directed tests

  task automatic erase_and_run_seq;
    int n;
    int k;
    erase_mem(n);                                   // Full erase since memory starts unknown
    for (k = 0; k < 8; k++) begin
      prog_q.push_back((k % 2) ? addi_word(k) : alu_word(k));
    end
    prog_q.push_back(HALT);
    load_prog();
    apply_reset();                                  // PC back to 0 with the program kept
    run_program(-1, 0);
  endtask

  task automatic jump_redirect;
    int n;
    erase_mem(n);
    prog_q = '{alu_word(1), alu_word(2), jump_word(6), addi_word(3), alu_word(4),
               alu_word(5), addi_word(6), alu_word(7), HALT};
    load_prog();
    apply_reset();
    run_program(-1, 0);                             // Expect 0 1 2 6 7
  endtask

  task automatic overwrite_flag;
    int n;
    erase_mem(n);
    prog_q = '{alu_word(10), alu_word(11), addi_word(12), addi_word(13)};
    load_prog();                                    // Flag stays low on fresh memory
    apply_reset();
    prog_q = '{alu_word(20), alu_word(21)};
    load_prog();                                    // Live words below, flag expected high
    erase_mem(n);                                   // Flag cleared by the erase
  endtask

  task automatic early_stop_erase;
    int n;
    erase_mem(n);
    prog_q = '{alu_word(3), addi_word(4), alu_word(5), addi_word(6)};
    load_prog();
    erase_mem(n);
    check(64'(n < RAM_DEPTH / 8), 64'd1, "erase did not stop early");
    run_program(-1, 0);                             // Halt word at 0 gives no strobe
  endtask

  task automatic pause_resume;
    int n;
    int k;
    erase_mem(n);
    for (k = 0; k < 12; k++) begin
      prog_q.push_back((k % 3 == 0) ? addi_word(k) : alu_word(k));
    end
    prog_q.push_back(HALT);
    load_prog();
    apply_reset();
    run_program(5, 6);
  endtask

  task automatic random_program;
    int          n;
    int          k;
    logic [31:0] w;
    erase_mem(n);
    for (k = 0; k < 20; k++) begin
      w = $random(seed);
      if (w[31:26] == fetch_pkg::OP_J || w[31:26] == fetch_pkg::OP_JAL ||
          w[31:26] == 6'h3f) begin
        w[31:26] = w[31:26] ^ 6'h10;                // Neither a jump nor the halt word
      end
      prog_q.push_back(w);
    end
    prog_q.push_back(HALT);
    load_prog();
    apply_reset();
    run_program(-1, 0);
  endtask

  ////////////////////
  // Sequence

  initial begin
    int k;
    i_rsta        = 1'b1;
    i_soft_reset  = 1'b0;
    i_load_strobe = 1'b0;
    i_load_word   = '0;
    i_run         = 1'b0;
    for (k = 0; k < RAM_DEPTH; k++) begin
      model_mem[k] = 32'h5a00_0000 ^ 32'(k * 32'h0001_0101);       // Never all ones
    end
    apply_reset();
    erase_and_run_seq();
    jump_redirect();
    overwrite_flag();
    early_stop_erase();
    pause_resume();
    random_program();
    if (mips_fetch_top_inst.fetch_ctrl_inst.fetch_ctrl_props.fail_count != 0) begin
      $display("Controller assertions failed %0d times",
               mips_fetch_top_inst.fetch_ctrl_inst.fetch_ctrl_props.fail_count);
      $display("TEST FAIL");
      $fatal(1, "Assertion failure");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule
